/* bench/mipsAssertions.sv */
`timescale 1ns/10ps

module mipsAssertions
(
	input logic clk,
	input logic reset,
	input logic memWrite,
	input logic halted
);
	int failCount = 0; // polled by the testbench

	quietInReset: assert property (@(posedge clk) reset |-> !memWrite)
	else
	begin
		$error("memWrite high while reset is active");
		failCount++;
	end

	// halt holds until reset
	haltSticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
	else
	begin
		$error("halted dropped without reset");
		failCount++;
	end

	singleStrobe: assert property (@(posedge clk) disable iff (reset) memWrite |=> !memWrite)
	else
	begin
		$error("memWrite high for two cycles in a row");
		failCount++;
	end

endmodule

bind mipsMulticycle mipsAssertions checks
(
	.clk(clk),
	.reset(reset),
	.memWrite(memWrite),
	.halted(halted)
);

/* bench/mipsTb.sv */
`timescale 1ns/10ps

module mipsTb;
	import mipsPkg::*;

	localparam int ResetCycles = 4;
	localparam int HaltTimeout = 200;
	localparam int QuietCycles = 6;
	localparam dataWord ResultAddr = 32'h0000_0108;
	localparam dataWord PoisonAddr = 32'h0000_0110;
	localparam dataWord FallMark = 32'h0001_0000;
	localparam dataWord TakenMark = 32'h0002_0000;

	typedef enum {
		KindAdd,
		KindSub,
		KindAnd,
		KindXor,
		KindSlt,
		KindBeq,
		KindBne,
		KindLui,
		KindJump,
		KindZeroReg
	} testKind;

	typedef struct {
		testKind kind;
		dataWord a;
		dataWord b;
		dataWord expected;
	} tableEntry;

	logic clk;
	logic reset;
	dataWord memReadData;
	dataWord memAddr;
	dataWord memWriteData;
	logic memWrite;
	logic halted;

	dataWord mem [0:1023];
	dataWord writeAddrs [$];
	dataWord writeValues [$];
	tableEntry stimTable [$];
	dataWord lfsrState;

	mipsMulticycle DUT
	(
		.clk(clk),
		.reset(reset),
		.memReadData(memReadData),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.memWrite(memWrite),
		.halted(halted)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
	begin
		memReadData <= mem[memAddr[11:2]]; // one-cycle read latency
		if (memWrite)
		begin
			mem[memAddr[11:2]] <= memWriteData;
			writeAddrs.push_back(memAddr);
			writeValues.push_back(memWriteData);
		end
	end

	always @(negedge clk)
	begin
		if (DUT.checks.failCount != 0)
			stopWithFailure("a bound assertion on the memory ports or halt failed");
	end

	task stopWithFailure(string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "run stopped at the first error");
	endtask

	task checkWord(dataWord got, dataWord exp, string what);
		if (got !== exp)
			stopWithFailure($sformatf("ERR @%0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task checkAddr(dataWord got, dataWord exp, string what);
		if (got !== exp)
			stopWithFailure($sformatf("ERR @%0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	// taps 32 22 2 1
	function logic stepLfsr();
		logic feedback;
		feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], feedback};
		return feedback;
	endfunction

	function dataWord randomWord();
		dataWord w;
		w = '0;
		for (int i = 0; i < 32; i++)
			w = {w[30:0], stepLfsr()};
		return w;
	endfunction

	function dataWord fillWord(int index);
		return (dataWord'(index) * 32'h9e37_79b9) ^ 32'h6b43_a9b5;
	endfunction

	function instrWord rType(regIndex rs, regIndex rt, regIndex rd, functField funct);
		instrWord w;
		w.rFields.opcode = OpRType;
		w.rFields.rs = rs;
		w.rFields.rt = rt;
		w.rFields.rd = rd;
		w.rFields.shamt = '0;
		w.rFields.funct = funct;
		return w;
	endfunction

	function instrWord iType(opcodeField op, regIndex rs, regIndex rt, logic [15:0] imm);
		instrWord w;
		w.iFields.opcode = op;
		w.iFields.rs = rs;
		w.iFields.rt = rt;
		w.iFields.immediate = imm;
		return w;
	endfunction

	function functField functFor(testKind kind);
		case (kind)
			KindSub: return FnSub;
			KindAnd: return FnAnd;
			KindXor: return FnXor;
			KindSlt: return FnSlt;
			default: return FnAdd;
		endcase
	endfunction

	// reference results from the instruction rules
	function dataWord expectedResult(testKind kind, dataWord a, dataWord b);
		case (kind)
			KindAdd: return a + b;
			KindSub: return a - b;
			KindAnd: return a & b;
			KindXor: return a ^ b;
			KindSlt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			KindBeq: return (a == b) ? TakenMark : FallMark;
			KindBne: return (a != b) ? TakenMark : FallMark;
			KindLui: return {a[15:0], 16'h0000};
			KindJump: return a;
			default: return '0; // register zero
		endcase
	endfunction

	task addEntry(testKind kind, dataWord a, dataWord b);
		tableEntry e;
		e.kind = kind;
		e.a = a;
		e.b = b;
		e.expected = expectedResult(kind, a, b);
		stimTable.push_back(e);
	endtask

	task addRandom(testKind kind);
		dataWord a;
		dataWord b;
		a = randomWord();
		b = randomWord();
		addEntry(kind, a, b);
	endtask

	task buildTable();
		dataWord same;
		addEntry(KindAdd, 32'h7fff_ffff, 32'h0000_0001); // wraps
		addEntry(KindSub, 32'h0000_0000, 32'h0000_0001);
		addEntry(KindAnd, 32'hf0f0_ff00, 32'h0ff0_f0f0);
		addEntry(KindXor, 32'hffff_0000, 32'h0f0f_0f0f);
		addEntry(KindSlt, 32'h8000_0000, 32'h0000_0001);
		addEntry(KindSlt, 32'h0000_0001, 32'hffff_ffff);
		addEntry(KindSlt, 32'h0000_0005, 32'h0000_0005);
		addEntry(KindBeq, 32'h1234_5678, 32'h1234_5678);
		addEntry(KindBeq, 32'h1234_5678, 32'h1234_5679);
		addEntry(KindBne, 32'h0bad_cafe, 32'h0bad_cafe);
		addEntry(KindBne, 32'h0bad_cafe, 32'h8bad_cafe);
		addEntry(KindLui, 32'h0000_beef, 32'h0000_0000);
		addEntry(KindJump, 32'h5eed_f00d, 32'h0000_0000);
		addEntry(KindZeroReg, 32'h0000_0003, 32'h0000_0004);
		for (int r = 0; r < 3; r++)
		begin
			addRandom(KindAdd);
			addRandom(KindSub);
			addRandom(KindAnd);
			addRandom(KindXor);
			addRandom(KindSlt);
			addRandom(KindBne);
			same = randomWord();
			addEntry(KindBeq, same, same);
		end
	endtask

	// data at 0x100 and 0x104, result at 0x108
	task loadProgram(tableEntry e);
		for (int i = 0; i < 1024; i++)
			mem[i] = fillWord(i);
		mem[64] = e.a;
		mem[65] = e.b;
		mem[0] = iType(OpLw, 0, 1, 16'h0100);
		mem[1] = iType(OpLw, 0, 2, 16'h0104);
		case (e.kind)
			KindBeq, KindBne:
			begin
				mem[2] = iType((e.kind == KindBeq) ? OpBeq : OpBne, 1, 2, 16'd3);
				mem[3] = iType(OpLui, 0, 4, FallMark[31:16]); // fall-through path
				mem[4] = iType(OpSw, 0, 4, ResultAddr[15:0]);
				mem[5] = rType(0, 0, 0, FnBreak);
				mem[6] = iType(OpLui, 0, 4, TakenMark[31:16]); // branch target
				mem[7] = iType(OpSw, 0, 4, ResultAddr[15:0]);
				mem[8] = rType(0, 0, 0, FnBreak);
			end
			KindLui:
			begin
				mem[2] = iType(OpLui, 0, 3, e.a[15:0]);
				mem[3] = iType(OpSw, 0, 3, ResultAddr[15:0]);
				mem[4] = rType(0, 0, 0, FnBreak);
			end
			KindJump:
			begin
				mem[2] = {OpJ, 26'd4};
				mem[3] = iType(OpSw, 0, 1, PoisonAddr[15:0]); // must be skipped
				mem[4] = iType(OpSw, 0, 1, ResultAddr[15:0]);
				mem[5] = rType(0, 0, 0, FnBreak);
			end
			KindZeroReg:
			begin
				mem[2] = rType(1, 2, 0, FnAdd);
				mem[3] = iType(OpSw, 0, 0, ResultAddr[15:0]);
				mem[4] = rType(0, 0, 0, FnBreak);
			end
			default:
			begin
				mem[2] = rType(1, 2, 3, functFor(e.kind));
				mem[3] = iType(OpSw, 0, 3, ResultAddr[15:0]);
				mem[4] = rType(0, 0, 0, FnBreak);
			end
		endcase
	endtask

	task waitForHalt(int index);
		int cycles;
		cycles = 0;
		while (halted !== 1'b1 && cycles < HaltTimeout)
		begin
			@(negedge clk);
			cycles++;
		end
		if (halted !== 1'b1)
			stopWithFailure($sformatf("Timed out: halted did not rise within %0d cycles on entry %0d",
				HaltTimeout, index));
	endtask

	task runEntry(int index);
		tableEntry e;
		int writesAtHalt;
		e = stimTable[index];
		@(posedge clk);
		reset <= 1'b1;
		loadProgram(e);
		writeAddrs.delete();
		writeValues.delete();
		repeat (ResetCycles) @(posedge clk);
		reset <= 1'b0;
		waitForHalt(index);
		writesAtHalt = writeAddrs.size();
		repeat (QuietCycles) @(negedge clk);
		checkWord(dataWord'(writeAddrs.size()), dataWord'(writesAtHalt), "writes after break");
		checkWord(dataWord'(writeAddrs.size()), 32'd1, $sformatf("entry %0d store count", index));
		checkAddr(writeAddrs[0], ResultAddr, $sformatf("entry %0d store address", index));
		checkWord(writeValues[0], e.expected, $sformatf("entry %0d stored value", index));
		checkWord(mem[ResultAddr[11:2]], e.expected, "result word in memory");
	endtask

	initial
	begin
		reset = 1'b1;
		memReadData = '0;
		lfsrState = 32'hb26128d8;
		buildTable();
		foreach (stimTable[i])
			runEntry(i);
		if (DUT.checks.failCount == 0)
		begin
			$display("=== PASS ===");
			$finish;
		end
		else
			stopWithFailure("a bound assertion failed during the run");
	end

endmodule

/* files.f */
hw/mipsPkg.sv
hw/aluUnit.sv
hw/registerFile.sv
hw/controlUnit.sv
hw/dataPath.sv
hw/mipsMulticycle.sv
bench/mipsAssertions.sv
bench/mipsTb.sv

/* hw/aluUnit.sv */
`timescale 1ns/10ps

module aluUnit
(
	input mipsPkg::dataWord a,
	input mipsPkg::dataWord b,
	input mipsPkg::aluOp op,
	output mipsPkg::dataWord result,
	output logic zero,
	output logic lessThan
);
	import mipsPkg::*;

	dataWord difference;

	assign difference = a - b; // wraps on overflow
	assign lessThan = $signed(a) < $signed(b);

	always_comb
	begin
		case (op)
			AluAdd: result = a + b;
			AluSub: result = difference;
			AluAnd: result = a & b;
			AluXor: result = a ^ b;
			AluSlt: result = {{(WordWidth-1){1'b0}}, lessThan};
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

/* hw/controlUnit.sv */
`timescale 1ns/10ps

module controlUnit
(
	input logic clk,
	input logic reset,
	input mipsPkg::instrWord instr,
	input logic zero,
	input logic lessThan,
	output logic pcWrite,
	output logic branchEnable,
	output logic branchOnEqual,
	output logic irWrite,
	output logic regWrite,
	output logic mdrWrite,
	output logic addrFromAluOut,
	output logic memWrite,
	output logic regDstRd,
	output logic halted,
	output mipsPkg::aluSrcASel aluSrcA,
	output mipsPkg::aluSrcBSel aluSrcB,
	output mipsPkg::aluOp aluControl,
	output mipsPkg::pcSrcSel pcSource,
	output mipsPkg::wbSel wbSource
);
	import mipsPkg::*;

	cpuState state;
	cpuState nextState;
	opcodeField opcode;
	functField funct;
	logic knownFunct;

	assign opcode = instr.rFields.opcode;
	assign funct = instr.rFields.funct;
	assign knownFunct = (funct == FnAdd) || (funct == FnSub) || (funct == FnAnd)
		|| (funct == FnXor) || (funct == FnSlt);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			state <= Fetch;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = Fetch;
		case (state)
			Fetch: nextState = WaitMem;
			WaitMem: nextState = IrLoad;
			IrLoad: nextState = Decode;
			Decode:
			begin
				case (opcode)
					OpRType:
					begin
						if (funct == FnBreak)
							nextState = Halt;
						else if (knownFunct)
							nextState = RExec;
						else
							nextState = Fetch; // unknown funct is a no-op
					end
					OpBeq, OpBne: nextState = Branch;
					OpLw, OpSw: nextState = MemAddr;
					OpLui: nextState = LuiWrite;
					OpJ: nextState = Jump;
					default: nextState = Fetch;
				endcase
			end
			RExec: nextState = RWrite;
			MemAddr: nextState = (opcode == OpLw) ? LoadRead : StoreWrite;
			LoadRead: nextState = LoadWait;
			LoadWait: nextState = LoadWrite;
			Halt: nextState = Halt;
			default: nextState = Fetch;
		endcase
	end

	always_comb
	begin
		pcWrite = 1'b0;
		branchEnable = 1'b0;
		branchOnEqual = 1'b0;
		irWrite = 1'b0;
		regWrite = 1'b0;
		mdrWrite = 1'b0;
		addrFromAluOut = 1'b0;
		memWrite = 1'b0;
		regDstRd = 1'b0;
		halted = 1'b0;
		aluSrcA = SrcAReg;
		aluSrcB = SrcBReg;
		aluControl = AluAdd;
		pcSource = PcAluResult;
		wbSource = WbAluOut;
		case (state)
			Fetch:
			begin
				aluSrcA = SrcAPc;
				aluSrcB = SrcBFour;
				pcWrite = 1'b1; // pc + 4
			end
			WaitMem: mdrWrite = 1'b1; // fetched word lands in mdr
			IrLoad: irWrite = 1'b1;
			Decode:
			begin
				aluSrcA = SrcAPc;
				aluSrcB = SrcBImmShift; // branch target into aluOut
			end
			RExec:
			begin
				case (funct)
					FnSub: aluControl = AluSub;
					FnAnd: aluControl = AluAnd;
					FnXor: aluControl = AluXor;
					FnSlt: aluControl = AluSlt;
					default: aluControl = AluAdd;
				endcase
			end
			RWrite:
			begin
				regDstRd = 1'b1;
				regWrite = 1'b1;
			end
			Branch:
			begin
				aluControl = AluSub;
				branchEnable = 1'b1;
				branchOnEqual = (opcode == OpBeq);
				pcSource = PcAluOut;
			end
			MemAddr: aluSrcB = SrcBImm;
			LoadRead: addrFromAluOut = 1'b1;
			LoadWait: mdrWrite = 1'b1;
			LoadWrite:
			begin
				wbSource = WbMemData;
				regWrite = 1'b1;
			end
			StoreWrite:
			begin
				addrFromAluOut = 1'b1;
				memWrite = 1'b1;
			end
			LuiWrite:
			begin
				wbSource = WbUpperImm;
				regWrite = 1'b1;
			end
			Jump:
			begin
				pcSource = PcJump;
				pcWrite = 1'b1;
			end
			Halt: halted = 1'b1;
			default: ;
		endcase
	end

endmodule

/* hw/dataPath.sv */
`timescale 1ns/10ps

module dataPath
(
	input logic clk,
	input logic reset,
	input mipsPkg::dataWord memReadData,
	input logic pcWrite,
	input logic branchEnable,
	input logic branchOnEqual,
	input logic irWrite,
	input logic regWrite,
	input logic mdrWrite,
	input logic addrFromAluOut,
	input logic regDstRd,
	input mipsPkg::aluSrcASel aluSrcA,
	input mipsPkg::aluSrcBSel aluSrcB,
	input mipsPkg::aluOp aluControl,
	input mipsPkg::pcSrcSel pcSource,
	input mipsPkg::wbSel wbSource,
	output mipsPkg::instrWord instr,
	output logic zero,
	output logic lessThan,
	output mipsPkg::dataWord memAddr,
	output mipsPkg::dataWord memWriteData
);
	import mipsPkg::*;

	dataWord pc;
	dataWord regA;
	dataWord regB;
	dataWord aluOut;
	dataWord mdr;
	dataWord readA;
	dataWord readB;
	dataWord aluA;
	dataWord aluB;
	dataWord aluResult;
	dataWord nextPc;
	dataWord writeData;
	dataWord signImm;
	regIndex writeReg;
	logic pcLoad;

	assign signImm = {{16{instr.iFields.immediate[15]}}, instr.iFields.immediate};

	// pc and control registers
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			pc <= ResetPc;
			instr <= '0;
		end
		else
		begin
			if (pcLoad)
				pc <= nextPc;
			if (irWrite)
				instr <= mdr;
		end
	end

	// payload registers
	always_ff @(posedge clk)
	begin
		regA <= readA;
		regB <= readB;
		aluOut <= aluResult;
		if (mdrWrite)
			mdr <= memReadData;
	end

	assign pcLoad = pcWrite || (branchEnable && (zero == branchOnEqual));

	always_comb
	begin
		case (pcSource)
			PcAluOut: nextPc = aluOut;
			PcJump: nextPc = {pc[31:28], instr.iFields.rs, instr.iFields.rt,
				instr.iFields.immediate, 2'b00};
			default: nextPc = aluResult;
		endcase
	end

	assign aluA = (aluSrcA == SrcAPc) ? pc : regA;

	always_comb
	begin
		case (aluSrcB)
			SrcBFour: aluB = 32'd4;
			SrcBImm: aluB = signImm;
			SrcBImmShift: aluB = {signImm[29:0], 2'b00};
			default: aluB = regB;
		endcase
	end

	always_comb
	begin
		case (wbSource)
			WbMemData: writeData = mdr;
			WbUpperImm: writeData = {instr.iFields.immediate, 16'h0000};
			default: writeData = aluOut;
		endcase
	end

	assign writeReg = regDstRd ? instr.rFields.rd : instr.iFields.rt;
	assign memAddr = addrFromAluOut ? aluOut : pc;
	assign memWriteData = regB;

	registerFile regFile
	(
		.clk(clk),
		.reset(reset),
		.readAddrA(instr.iFields.rs),
		.readAddrB(instr.iFields.rt),
		.writeAddr(writeReg),
		.writeData(writeData),
		.writeEnable(regWrite),
		.readDataA(readA),
		.readDataB(readB)
	);

	aluUnit alu
	(
		.a(aluA),
		.b(aluB),
		.op(aluControl),
		.result(aluResult),
		.zero(zero),
		.lessThan(lessThan)
	);

endmodule

/* hw/mipsMulticycle.sv */
`timescale 1ns/10ps

module mipsMulticycle
(
	input logic clk,
	input logic reset,
	input mipsPkg::dataWord memReadData,
	output mipsPkg::dataWord memAddr,
	output mipsPkg::dataWord memWriteData,
	output logic memWrite,
	output logic halted
);
	import mipsPkg::*;

	instrWord instr;
	logic zero;
	logic lessThan;
	logic pcWrite;
	logic branchEnable;
	logic branchOnEqual;
	logic irWrite;
	logic regWrite;
	logic mdrWrite;
	logic addrFromAluOut;
	logic regDstRd;
	aluSrcASel aluSrcA;
	aluSrcBSel aluSrcB;
	aluOp aluControl;
	pcSrcSel pcSource;
	wbSel wbSource;

	controlUnit ctrl
	(
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.zero(zero),
		.lessThan(lessThan),
		.pcWrite(pcWrite),
		.branchEnable(branchEnable),
		.branchOnEqual(branchOnEqual),
		.irWrite(irWrite),
		.regWrite(regWrite),
		.mdrWrite(mdrWrite),
		.addrFromAluOut(addrFromAluOut),
		.memWrite(memWrite),
		.regDstRd(regDstRd),
		.halted(halted),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.aluControl(aluControl),
		.pcSource(pcSource),
		.wbSource(wbSource)
	);

	dataPath dp
	(
		.clk(clk),
		.reset(reset),
		.memReadData(memReadData),
		.pcWrite(pcWrite),
		.branchEnable(branchEnable),
		.branchOnEqual(branchOnEqual),
		.irWrite(irWrite),
		.regWrite(regWrite),
		.mdrWrite(mdrWrite),
		.addrFromAluOut(addrFromAluOut),
		.regDstRd(regDstRd),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.aluControl(aluControl),
		.pcSource(pcSource),
		.wbSource(wbSource),
		.instr(instr),
		.zero(zero),
		.lessThan(lessThan),
		.memAddr(memAddr),
		.memWriteData(memWriteData)
	);

endmodule

/* hw/mipsPkg.sv */
package mipsPkg;

	localparam int WordWidth = 32;
	localparam int RegIndexWidth = 5;

	typedef logic [WordWidth-1:0] dataWord;
	typedef logic [RegIndexWidth-1:0] regIndex;
	typedef logic [5:0] opcodeField;
	typedef logic [5:0] functField;

	localparam opcodeField OpRType = 6'h00;
	localparam opcodeField OpJ = 6'h02;
	localparam opcodeField OpBeq = 6'h04;
	localparam opcodeField OpBne = 6'h05;
	localparam opcodeField OpLui = 6'h0f;
	localparam opcodeField OpLw = 6'h23;
	localparam opcodeField OpSw = 6'h2b;

	localparam functField FnBreak = 6'h0d;
	localparam functField FnAdd = 6'h20;
	localparam functField FnSub = 6'h22;
	localparam functField FnAnd = 6'h24;
	localparam functField FnXor = 6'h26;
	localparam functField FnSlt = 6'h2a;

	localparam dataWord ResetPc = 32'h0000_0000;

	typedef enum logic [2:0] {
		AluAdd,
		AluSub,
		AluAnd,
		AluXor,
		AluSlt
	} aluOp;

	typedef enum logic [3:0] {
		Fetch,
		WaitMem, // memory answers the fetch
		IrLoad,
		Decode,
		RExec,
		RWrite,
		Branch,
		MemAddr,
		LoadRead,
		LoadWait,
		LoadWrite,
		StoreWrite,
		LuiWrite,
		Jump,
		Halt
	} cpuState;

	typedef enum logic {
		SrcAPc,
		SrcAReg
	} aluSrcASel;

	typedef enum logic [1:0] {
		SrcBReg,
		SrcBFour,
		SrcBImm,
		SrcBImmShift // branch offset in words
	} aluSrcBSel;

	typedef enum logic [1:0] {
		PcAluResult,
		PcAluOut,
		PcJump
	} pcSrcSel;

	typedef enum logic [1:0] {
		WbAluOut,
		WbMemData,
		WbUpperImm
	} wbSel;

	typedef struct packed {
		opcodeField opcode;
		regIndex rs;
		regIndex rt;
		regIndex rd;
		logic [4:0] shamt;
		functField funct;
	} rFieldsT;

	typedef struct packed {
		opcodeField opcode;
		regIndex rs;
		regIndex rt;
		logic [15:0] immediate;
	} iFieldsT;

	// same word seen as R or I format
	typedef union packed {
		rFieldsT rFields;
		iFieldsT iFields;
	} instrWord;

endpackage

/* hw/registerFile.sv */
`timescale 1ns/10ps

module registerFile
(
	input logic clk,
	input logic reset,
	input mipsPkg::regIndex readAddrA,
	input mipsPkg::regIndex readAddrB,
	input mipsPkg::regIndex writeAddr,
	input mipsPkg::dataWord writeData,
	input logic writeEnable,
	output mipsPkg::dataWord readDataA,
	output mipsPkg::dataWord readDataB
);
	import mipsPkg::*;

	dataWord regs [1:31]; // no storage behind register zero

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (writeEnable && writeAddr != '0)
			regs[writeAddr] <= writeData;
	end

	assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule
